//--- Bender.yml
package:
  name: ipod_ctrl

sources:
  - common/ipod_pkg.sv
  - control/control_fsm.sv
  - control/speed_buttons.sv
  - control/speed_reg.sv
  - playback/addr_sequencer.sv
  - rtl/hex_display.sv
  - rtl/ipod_ctrl_top.sv
  - target: test
    files:
      - tb/ipod_ctrl_checker.sv
      - tb/ipod_ctrl_tb.sv

//--- common/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  //==========================================================================
  // Keyboard
  //==========================================================================

  typedef logic [7:0] ascii_t;

  // Uppercase ASCII letters from the keyboard decoder
  localparam ascii_t key_play    = 8'h45;
  localparam ascii_t key_stop    = 8'h44;
  localparam ascii_t key_back    = 8'h42;
  localparam ascii_t key_restart = 8'h52;

  // Transport states, encodings kept from the board design
  typedef enum logic [2:0] {
    STOP      = 3'b001,
    PLAY      = 3'b011,
    SPD_UP    = 3'b010,
    SPD_DWN   = 3'b110,
    PLAY_BACK = 3'b101,
    RESTART   = 3'b100
  } play_state_e;

  //==========================================================================
  // Flash addressing and sample timing
  //==========================================================================

  typedef logic [20:0] addr_t;

  // One 16-bit sample spans two flash words
  localparam addr_t addr_step = 21'd2;

  typedef logic [15:0] period_t;

  // 50 MHz / 2272 is roughly 22 kHz
  localparam period_t base_sample_period = 16'd2272;

  //==========================================================================
  // Speed control
  //==========================================================================

  typedef logic signed [15:0] speed_t;

  localparam speed_t speed_step  = 16'sd100;
  localparam speed_t speed_limit = 16'sd1000;

  // Ten steps per second at 50 MHz
  localparam int unsigned repeat_period_default = 5_000_000;

  typedef struct packed {
    logic up;
    logic down;
    logic normal;
  } buttons_t;

  typedef struct packed {
    logic up;
    logic down;
    logic normal;
  } speed_evt_t;

  //==========================================================================
  // Seven-segment display
  //==========================================================================

  // Active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

  typedef struct packed {
    seg_t digit3;
    seg_t digit2;
    seg_t digit1;
    seg_t digit0;
  } hex_digits_t;

endpackage

`default_nettype wire

//--- control/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm
  import ipod_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst,
  input  ascii_t      key_ascii,
  input  speed_evt_t  speed_evt,
  output play_state_e state
);

  play_state_e state_next;

  //==========================================================================
  // Next-state logic
  //==========================================================================

  always_comb
  begin
    state_next = state;
    case (state)
      STOP:
      begin
        if (key_ascii == key_play)
          state_next = PLAY;
      end
      PLAY:
      begin
        // Keys take priority over speed steps
        if (key_ascii == key_stop)
          state_next = STOP;
        else if (key_ascii == key_back)
          state_next = PLAY_BACK;
        else if (key_ascii == key_restart)
          state_next = RESTART;
        else if (speed_evt.up)
          state_next = SPD_UP;
        else if (speed_evt.down)
          state_next = SPD_DWN;
      end
      SPD_UP, SPD_DWN:
      begin
        // Single-cycle marker states
        state_next = PLAY;
      end
      PLAY_BACK:
      begin
        if (key_ascii != key_back)
          state_next = PLAY;
      end
      RESTART:
      begin
        if (key_ascii != key_restart)
          state_next = PLAY;
      end
      default:
      begin
        state_next = STOP;
      end
    endcase
  end

  //==========================================================================
  // State register
  //==========================================================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state <= STOP;
    end
    else
    begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

//--- control/speed_buttons.sv
`timescale 1ns/1ps
`default_nettype none

module speed_buttons
  import ipod_pkg::*;
#(
  parameter int unsigned repeat_period = repeat_period_default
)
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  buttons_t   buttons,
  output speed_evt_t speed_evt
);

  localparam int cnt_w = (repeat_period > 1) ? $clog2(repeat_period) : 1;

  buttons_t         btn_meta;
  buttons_t         btn_sync;
  logic [cnt_w-1:0] repeat_cnt;
  logic             repeat_wrap;

  // Two-flop synchronizer for the raw button levels
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      btn_meta <= '0;
      btn_sync <= '0;
    end
    else
    begin
      btn_meta <= buttons;
      btn_sync <= btn_meta;
    end
  end

  //==========================================================================
  // Repeat counter, shared by both directions
  //==========================================================================

  assign repeat_wrap = (repeat_cnt == cnt_w'(repeat_period - 1));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      repeat_cnt <= '0;
    end
    else if (repeat_wrap)
    begin
      repeat_cnt <= '0;
    end
    else
    begin
      repeat_cnt <= repeat_cnt + 1'b1;
    end
  end

  // Up wins when both are held
  always_comb
  begin
    speed_evt.up     = repeat_wrap & btn_sync.up;
    speed_evt.down   = repeat_wrap & ~btn_sync.up & btn_sync.down;
    speed_evt.normal = btn_sync.normal;
  end

endmodule

`default_nettype wire

//--- control/speed_reg.sv
`timescale 1ns/1ps
`default_nettype none

module speed_reg
  import ipod_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst,
  input  speed_evt_t speed_evt,
  output period_t    sample_period
);

  speed_t offset;
  speed_t offset_dec;
  speed_t offset_inc;

  assign offset_dec = offset - speed_step;
  assign offset_inc = offset + speed_step;

  // Up shortens the period, down lengthens it
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      offset <= '0;
    end
    else if (speed_evt.normal)
    begin
      offset <= '0;
    end
    else if (speed_evt.up)
    begin
      offset <= (offset_dec < -speed_limit) ? -speed_limit : offset_dec;
    end
    else if (speed_evt.down)
    begin
      offset <= (offset_inc > speed_limit) ? speed_limit : offset_inc;
    end
  end

  // Two's complement add, offset never exceeds the base
  assign sample_period = base_sample_period + period_t'(offset);

endmodule

`default_nettype wire

//--- list.f
common/ipod_pkg.sv
control/control_fsm.sv
control/speed_buttons.sv
control/speed_reg.sv
playback/addr_sequencer.sv
rtl/hex_display.sv
rtl/ipod_ctrl_top.sv
tb/ipod_ctrl_checker.sv
tb/ipod_ctrl_tb.sv

//--- playback/addr_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module addr_sequencer
  import ipod_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  play_state_e state,
  input  period_t     sample_period,
  output addr_t       flash_addr,
  output logic        sample_strobe
);

  period_t timer;
  logic    wrap;

  // Greater-or-equal so a shorter period never strands the timer
  assign wrap = (timer >= sample_period - 16'd1);

  //==========================================================================
  // Sample timer
  //==========================================================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      timer         <= '0;
      sample_strobe <= 1'b0;
    end
    else if (state == RESTART)
    begin
      timer         <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= wrap;
      if (wrap)
        timer <= '0;
      else
        timer <= timer + 16'd1;
    end
  end

  //==========================================================================
  // Flash word address
  //==========================================================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      flash_addr <= '0;
    end
    else if (state == RESTART)
    begin
      flash_addr <= '0;
    end
    else if (wrap)
    begin
      case (state)
        PLAY, SPD_UP, SPD_DWN: flash_addr <= flash_addr + addr_step;
        PLAY_BACK:             flash_addr <= flash_addr - addr_step;
        default:               flash_addr <= flash_addr;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display
  import ipod_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  period_t     sample_period,
  output hex_digits_t hex
);

  // Nibble to active-low segments, gfedcba
  function automatic seg_t seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // Blank until the first clock after reset
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      hex <= '1;
    end
    else
    begin
      hex.digit0 <= seg_decode(sample_period[3:0]);
      hex.digit1 <= seg_decode(sample_period[7:4]);
      hex.digit2 <= seg_decode(sample_period[11:8]);
      hex.digit3 <= seg_decode(sample_period[15:12]);
    end
  end

endmodule

`default_nettype wire

//--- rtl/ipod_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_ctrl_top
  import ipod_pkg::*;
#(
  parameter int unsigned repeat_period = repeat_period_default
)
(
  input  wire logic   clk,
  input  wire logic   rst,
  input  ascii_t      key_ascii,
  input  buttons_t    buttons,
  output addr_t       flash_addr,
  output logic        sample_strobe,
  output play_state_e play_state,
  output hex_digits_t hex
);

  speed_evt_t speed_evt;
  period_t    sample_period;

  //==========================================================================
  // Speed path
  //==========================================================================

  speed_buttons #(
    .repeat_period (repeat_period)
  ) u_speed_buttons (
    .clk       (clk),
    .rst       (rst),
    .buttons   (buttons),
    .speed_evt (speed_evt)
  );

  speed_reg u_speed_reg (
    .clk           (clk),
    .rst           (rst),
    .speed_evt     (speed_evt),
    .sample_period (sample_period)
  );

  //==========================================================================
  // Transport and playback
  //==========================================================================

  control_fsm u_control_fsm (
    .clk       (clk),
    .rst       (rst),
    .key_ascii (key_ascii),
    .speed_evt (speed_evt),
    .state     (play_state)
  );

  addr_sequencer u_addr_sequencer (
    .clk           (clk),
    .rst           (rst),
    .state         (play_state),
    .sample_period (sample_period),
    .flash_addr    (flash_addr),
    .sample_strobe (sample_strobe)
  );

  // Period readout
  hex_display u_hex_display (
    .clk           (clk),
    .rst           (rst),
    .sample_period (sample_period),
    .hex           (hex)
  );

endmodule

`default_nettype wire

//--- tb/ipod_ctrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_ctrl_checker
  import ipod_pkg::*;
(
  input wire logic   clk,
  input wire logic   rst,
  input play_state_e play_state,
  input logic        sample_strobe,
  input addr_t       flash_addr
);

  // Number of failed assertions
  int fail_count = 0;

  // Speed marker states last a single cycle
  property spd_returns_to_play;
    @(posedge clk) disable iff (rst)
      (play_state == SPD_UP || play_state == SPD_DWN) |=> (play_state == PLAY);
  endproperty

  property strobe_single_cycle;
    @(posedge clk) disable iff (rst)
      sample_strobe |=> !sample_strobe;
  endproperty

  // Restart clears the address on the following clock
  property restart_clears_addr;
    @(posedge clk) disable iff (rst)
      (play_state == RESTART) |=> (flash_addr == '0);
  endproperty

  assert property (spd_returns_to_play)
  else
  begin
    $error("Speed state was not followed by PLAY");
    fail_count++;
  end

  assert property (strobe_single_cycle)
  else
  begin
    $error("sample_strobe stayed high for two cycles");
    fail_count++;
  end

  assert property (restart_clears_addr)
  else
  begin
    $error("flash_addr not zero one cycle into RESTART");
    fail_count++;
  end

endmodule

`default_nettype wire

//--- tb/ipod_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_ctrl_tb
  import ipod_pkg::*;
();

  localparam int clk_period    = 8;
  localparam int rst_cycles    = 8;
  localparam int tb_repeat     = 200;
  localparam int margin_cycles = 20000;
  localparam int strobe_worst  = int'(base_sample_period) + int'(speed_limit);

  logic        clk;
  logic        rst;
  ascii_t      key_ascii;
  buttons_t    buttons;
  addr_t       flash_addr;
  logic        sample_strobe;
  play_state_e play_state;
  hex_digits_t hex;

  string trace_lines[$];
  logic  trace_loaded;
  int    limit_cycles;
  int    err_count;
  int    test_count;
  int    test_fail;
  int    test_errs;
  string test_name;
  int    model_offset;

  ipod_ctrl_top #(
    .repeat_period (tb_repeat)
  ) UUT (
    .clk           (clk),
    .rst           (rst),
    .key_ascii     (key_ascii),
    .buttons       (buttons),
    .flash_addr    (flash_addr),
    .sample_strobe (sample_strobe),
    .play_state    (play_state),
    .hex           (hex)
  );

  bind ipod_ctrl_top ipod_ctrl_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .play_state    (play_state),
    .sample_strobe (sample_strobe),
    .flash_addr    (flash_addr)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(clk_period / 2) clk = ~clk;
  end

  //==========================================================================
  // Display decoding and checks
  //==========================================================================

  // Active-low gfedcba patterns back to a nibble
  // Returns -1 for a pattern that is no digit
  function automatic int seg_to_nibble(input seg_t seg);
    case (seg)
      7'h40:   return 0;
      7'h79:   return 1;
      7'h24:   return 2;
      7'h30:   return 3;
      7'h19:   return 4;
      7'h12:   return 5;
      7'h02:   return 6;
      7'h78:   return 7;
      7'h00:   return 8;
      7'h10:   return 9;
      7'h08:   return 10;
      7'h03:   return 11;
      7'h46:   return 12;
      7'h21:   return 13;
      7'h06:   return 14;
      7'h0E:   return 15;
      default: return -1;
    endcase
  endfunction

  function automatic int display_value(input hex_digits_t h);
    int value;
    int nib;
    value = 0;
    for (int i = 3; i >= 0; i--)
    begin
      nib = seg_to_nibble(h[i*7 +: 7]);
      if (nib < 0)
        return -1;
      value = (value << 4) | nib;
    end
    return value;
  endfunction

  function automatic play_state_e state_from_name(input string name);
    case (name)
      "STOP":      return STOP;
      "PLAY":      return PLAY;
      "SPD_UP":    return SPD_UP;
      "SPD_DWN":   return SPD_DWN;
      "PLAY_BACK": return PLAY_BACK;
      "RESTART":   return RESTART;
      default:     return play_state_e'(3'b000);
    endcase
  endfunction

  // Offset moved by delta and saturated at the limit
  function automatic int stepped_offset(input int offset, input int delta);
    int value;
    value = offset + delta;
    if (value > int'(speed_limit))
      value = int'(speed_limit);
    else if (value < -int'(speed_limit))
      value = -int'(speed_limit);
    return value;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("ERR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    err_count++;
    test_errs++;
  endtask

  task automatic finish_test();
    if (test_name == "")
      return;
    test_count++;
    if (test_errs == 0)
    begin
      $display("Test %s passed", test_name);
    end
    else
    begin
      test_fail++;
      $display("Test %s failed with %0d errors", test_name, test_errs);
    end
    test_name = "";
  endtask

  //==========================================================================
  // Stimulus helpers starting and ending on a falling edge
  //==========================================================================

  task automatic set_key(input ascii_t code);
    key_ascii = code;
    repeat (2) @(negedge clk);
  endtask

  task automatic wait_strobes(input int n);
    int seen;
    seen = 0;
    while (seen < n)
    begin
      @(negedge clk);
      if (sample_strobe)
        seen++;
    end
  endtask

  // Release half a repeat period after the last wanted step
  task automatic hold_button(input string dir, input int steps);
    int start_value;
    start_value = display_value(hex);
    if (dir == "up")
    begin
      buttons.up = 1'b1;
    end
    else if (dir == "down")
    begin
      buttons.down = 1'b1;
    end
    else
    begin
      report_failure($sformatf("unknown button '%s' in trace", dir));
      return;
    end
    while (display_value(hex) == start_value)
      @(negedge clk);
    repeat ((steps - 1) * tb_repeat + tb_repeat / 2)
      @(negedge clk);
    buttons.up   = 1'b0;
    buttons.down = 1'b0;
    repeat (4) @(negedge clk);
    // Up shortens the period and down lengthens it
    if (dir == "up")
      model_offset = stepped_offset(model_offset, -steps * int'(speed_step));
    else
      model_offset = stepped_offset(model_offset, steps * int'(speed_step));
  endtask

  task automatic press_normal();
    buttons.normal = 1'b1;
    repeat (4) @(negedge clk);
    buttons.normal = 1'b0;
    repeat (4) @(negedge clk);
    model_offset = 0;
  endtask

  // Measure the interval after the first strobe
  task automatic check_spacing();
    int cycles;
    cycles = 0;
    wait_strobes(1);
    do
    begin
      @(negedge clk);
      cycles++;
    end while (!sample_strobe);
    check_value("strobe_spacing", int'(base_sample_period) + model_offset, cycles);
  endtask

  task automatic step_speed_state();
    buttons.up = 1'b1;
    while (play_state != SPD_UP)
      @(negedge clk);
    buttons.up = 1'b0;
    @(negedge clk);
    check_value("play_state", PLAY, play_state);
    repeat (4) @(negedge clk);
    model_offset = stepped_offset(model_offset, -int'(speed_step));
  endtask

  //==========================================================================
  // Trace handling
  //==========================================================================

  task automatic load_trace();
    int    fd;
    int    num;
    string line;
    string cmd;
    string word;
    limit_cycles = margin_cycles;
    fd = $fopen("tb/ipod_trace.txt", "r");
    if (fd == 0)
    begin
      report_failure("cannot open trace file tb/ipod_trace.txt");
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      trace_lines.push_back(line);
      num = 0;
      void'($sscanf(line, "%s", cmd));
      if (cmd == "hold")
      begin
        void'($sscanf(line, "%s %s %d", cmd, word, num));
        limit_cycles += (num + 1) * tb_repeat;
      end
      else
      begin
        void'($sscanf(line, "%s %d", cmd, num));
        if (cmd == "wait")
          limit_cycles += num * strobe_worst;
        else if (cmd == "spacing")
          limit_cycles += 2 * strobe_worst;
        else if (cmd == "speed_state")
          limit_cycles += 2 * tb_repeat;
        else if (cmd == "idle")
          limit_cycles += num;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_line(input string line);
    string cmd;
    string word;
    int    num;
    num  = 0;
    word = "";
    void'($sscanf(line, "%s", cmd));
    case (cmd)
      "test":
      begin
        void'($sscanf(line, "%s %s", cmd, word));
        finish_test();
        test_name = word;
        test_errs = 0;
      end
      "key":
      begin
        void'($sscanf(line, "%s %h", cmd, num));
        set_key(ascii_t'(num));
      end
      "hold":
      begin
        void'($sscanf(line, "%s %s %d", cmd, word, num));
        hold_button(word, num);
      end
      "normal":
        press_normal();
      "wait":
      begin
        void'($sscanf(line, "%s %d", cmd, num));
        wait_strobes(num);
      end
      "idle":
      begin
        void'($sscanf(line, "%s %d", cmd, num));
        repeat (num) @(negedge clk);
      end
      "spacing":
        check_spacing();
      "speed_state":
        step_speed_state();
      "state":
      begin
        void'($sscanf(line, "%s %s", cmd, word));
        check_value("play_state", state_from_name(word), play_state);
      end
      "addr":
      begin
        void'($sscanf(line, "%s %h", cmd, num));
        check_value("flash_addr", num, flash_addr);
      end
      "period":
      begin
        void'($sscanf(line, "%s %d", cmd, num));
        if (display_value(hex) < 0)
          report_failure("display shows a segment pattern that is not a hex digit");
        else
          check_value("hex_period", num, display_value(hex));
      end
      default:
        report_failure($sformatf("unknown trace command '%s'", cmd));
    endcase
  endtask

  //==========================================================================
  // Main sequence and watchdog
  //==========================================================================

  initial
  begin
    rst          = 1'b1;
    key_ascii    = '0;
    buttons      = '0;
    trace_loaded = 1'b0;
    err_count    = 0;
    test_count   = 0;
    test_fail    = 0;
    test_errs    = 0;
    test_name    = "";
    model_offset = 0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    foreach (trace_lines[i])
      run_line(trace_lines[i]);
    finish_test();
    if (UUT.u_checker.fail_count != 0)
      report_failure($sformatf("%0d assertion failures in the bound checker",
                               UUT.u_checker.fail_count));
    $display("Tests run %0d, failed %0d, errors %0d", test_count, test_fail, err_count);
    if (err_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    wait (trace_loaded === 1'b1);
    repeat (rst_cycles + limit_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the trace did not finish",
             rst_cycles + limit_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/ipod_trace.txt
# Columns: command, then its arguments (key and addr in hex, counts and period in decimal)
# Commands: test, key, hold up|down, normal, wait, idle, spacing, speed_state, state, addr, period
test after_reset
state STOP
addr 0
period 2272
wait 2
addr 0
test transport
key 45
state PLAY
key 44
state STOP
key 45
state PLAY
key 52
state RESTART
addr 0
idle 100
state RESTART
addr 0
key 45
state PLAY
test address_stepping
wait 5
addr 00000a
key 42
state PLAY_BACK
wait 3
addr 000004
wait 3
addr 1ffffe
key 45
state PLAY
test speed_steps
hold up 3
period 1972
normal
period 2272
hold down 3
period 2572
normal
hold up 12
period 1272
normal
hold down 12
period 3272
normal
period 2272
test strobe_spacing
spacing
hold up 2
period 2072
spacing
normal
spacing
test speed_state
state PLAY
speed_state
period 2172
